//--- bench/mmu_input.txt
# W addr data | R addr expected | T vaddr hit paddr uncache exccode | I cycles timer_int
# every field is hex
R 0 8
T 1234abcd 1 1234abcd 1 0
W 180 ffffffff
R 180 ee000039
W 180 82000011
W 181 84000001
W 0 10
T 80012340 1 20012340 0 0
W 180 82000001
T 80012340 1 20012340 1 0
T 20000000 0 0 0 3f
W 0 13
T 80012340 0 0 0 3f
W 181 84000008
T 80012340 1 40012340 1 0
W 0 c
R 0 c
W 41 9
R 42 8
I c 1
R 5 800
I 3 1
W 44 1
I 1 0
R 5 0
R 42 0

//--- bench/tb_mmu_top.sv
`include "mmu_defines.svh"

module tb_mmu_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CMDS = 64;

   logic                     clk;
   logic                     rst_n;
   logic                     csr_wen;
   logic [`MMU_CSR_BITS-1:0] csr_waddr;
   logic [`MMU_GRLEN-1:0]    csr_wdata;
   logic [`MMU_CSR_BITS-1:0] csr_raddr;
   logic [`MMU_GRLEN-1:0]    csr_rdata;
   logic                     tlb_req;
   logic                     tlb_wr;
   logic [`MMU_GRLEN-1:0]    tlb_vaddr;
   logic                     cache_recv;
   logic                     finish;
   logic                     hit;
   logic [`MMU_PABITS-1:0]   paddr;
   logic                     uncache;
   logic [`MMU_EXC_BITS-1:0] exccode;
   logic                     timer_int;

   logic [7:0]  cmd_mem [MAX_CMDS];
   logic [31:0] arg_mem [MAX_CMDS][5];
   int          n_cmds;
   int          wait_total;
   int          limit = 0;
   int          cycles;
   int          checks;
   int          errors;

   mmu_top u_mmu_top (
      .i_clk             (clk       ),
      .i_rst_n           (rst_n     ),
      .i_csr_wen         (csr_wen   ),
      .i_csr_waddr       (csr_waddr ),
      .i_csr_wdata       (csr_wdata ),
      .i_csr_raddr       (csr_raddr ),
      .o_csr_rdata       (csr_rdata ),
      .i_data_tlb_req    (tlb_req   ),
      .i_data_tlb_wr     (tlb_wr    ),
      .i_data_tlb_vaddr  (tlb_vaddr ),
      .i_dtlb_cache_recv (cache_recv),
      .o_dtlb_finish     (finish    ),
      .o_dtlb_hit        (hit       ),
      .o_dtlb_paddr      (paddr     ),
      .o_dtlb_uncache    (uncache   ),
      .o_dtlb_exccode    (exccode   ),
      .o_timer_int       (timer_int )
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // limit is set once the command file is loaded
   initial begin
      cycles = 0;
      wait (limit > 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the command list did not complete", cycles);
      $display("CHECKS FAILED");
      $finish;
   end

   task automatic compare_word(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic load_commands();
      int            fd;
      int            n;
      bit            more;
      logic [7:0]    cmd;
      logic [31:0]   a0, a1, a2, a3, a4;
      logic [1023:0] skip;
      fd = $fopen("bench/mmu_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open bench/mmu_input.txt");
         errors++;
         return;
      end
      more = 1'b1;
      while (more) begin
         n = $fscanf(fd, " %c", cmd);
         if (n != 1) begin
            more = 1'b0;
         end else if (cmd == "#") begin
            n = $fgets(skip, fd);   // comment line
         end else begin
            a2 = '0;
            a3 = '0;
            a4 = '0;
            case (cmd)
               "W", "R", "I": n = $fscanf(fd, "%h %h", a0, a1);
               "T":           n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
               default: begin
                  $display("unknown command %c in the input file", cmd);
                  errors++;
                  n = 0;
               end
            endcase
            if (n > 0 && n_cmds < MAX_CMDS) begin
               cmd_mem[n_cmds]    = cmd;
               arg_mem[n_cmds][0] = a0;
               arg_mem[n_cmds][1] = a1;
               arg_mem[n_cmds][2] = a2;
               arg_mem[n_cmds][3] = a3;
               arg_mem[n_cmds][4] = a4;
               if (cmd == "I") wait_total += int'(a0);
               n_cmds++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic write_csr(input logic [31:0] addr, input logic [31:0] data);
      csr_wen   = 1'b1;
      csr_waddr = addr[`MMU_CSR_BITS-1:0];
      csr_wdata = data;
      @(negedge clk);
      csr_wen   = 1'b0;
   endtask

   task automatic read_csr(input logic [31:0] addr, input logic [31:0] exp);
      csr_raddr = addr[`MMU_CSR_BITS-1:0];
      #5;
      compare_word("o_csr_rdata", exp, csr_rdata);
      @(negedge clk);
   endtask

   task automatic check_result(input logic [31:0] e_hit, input logic [31:0] e_paddr,
                               input logic [31:0] e_unc, input logic [31:0] e_exc);
      compare_word("o_dtlb_finish", 32'd1, 32'(finish));
      compare_word("o_dtlb_hit", e_hit, 32'(hit));
      compare_word("o_dtlb_paddr", e_paddr, paddr);
      compare_word("o_dtlb_uncache", e_unc, 32'(uncache));
      compare_word("o_dtlb_exccode", e_exc, 32'(exccode));
   endtask

   task automatic translate(input logic [31:0] vaddr, input logic [31:0] e_hit,
                            input logic [31:0] e_paddr, input logic [31:0] e_unc,
                            input logic [31:0] e_exc);
      int stall;
      int guard;
      stall     = $urandom % 6;
      guard     = 0;
      tlb_req   = 1'b1;
      tlb_wr    = 1'b0;
      tlb_vaddr = vaddr;
      @(negedge clk);
      tlb_req   = 1'b0;
      tlb_vaddr = ~vaddr;   // a moving address would leak into an unheld result
      #5;
      while (!finish && guard < 8) begin
         @(negedge clk);
         #5;
         guard++;
      end
      if (!finish) begin
         errors++;
         $display("no finish came back for the translation of %h", vaddr);
      end else begin
         check_result(e_hit, e_paddr, e_unc, e_exc);
         repeat (stall) begin   // result must hold while the cache stalls
            @(negedge clk);
            #5;
            check_result(e_hit, e_paddr, e_unc, e_exc);
         end
         @(negedge clk);
         cache_recv = 1'b1;
         @(negedge clk);
         cache_recv = 1'b0;
         #5;
         compare_word("o_dtlb_finish", 32'd0, 32'(finish));
      end
      @(negedge clk);
   endtask

   task automatic wait_timer(input logic [31:0] n_cyc, input logic [31:0] e_int);
      repeat (n_cyc) @(negedge clk);
      #5;
      compare_word("o_timer_int", e_int, 32'(timer_int));
      @(negedge clk);
   endtask

   initial begin
      int idx;
      int errs_before;
      rst_n      = 1'b0;
      csr_wen    = 1'b0;
      csr_waddr  = '0;
      csr_wdata  = '0;
      csr_raddr  = '0;
      tlb_req    = 1'b0;
      tlb_wr     = 1'b0;
      tlb_vaddr  = '0;
      cache_recv = 1'b0;
      checks     = 0;
      errors     = 0;
      n_cmds     = 0;
      wait_total = 0;
      void'($urandom(29));
      load_commands();
      limit = 40 * n_cmds + wait_total + 2;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      idx = 0;
      while (idx < n_cmds) begin
         errs_before = errors;
         case (cmd_mem[idx])
            "W": write_csr(arg_mem[idx][0], arg_mem[idx][1]);
            "R": read_csr(arg_mem[idx][0], arg_mem[idx][1]);
            "T": translate(arg_mem[idx][0], arg_mem[idx][1], arg_mem[idx][2],
                           arg_mem[idx][3], arg_mem[idx][4]);
            default: wait_timer(arg_mem[idx][0], arg_mem[idx][1]);
         endcase
         $display("cmd %0d %c %s", idx, cmd_mem[idx],
                  (errors == errs_before) ? "ok" : "mismatch");
         idx++;
      end
      $display("%0d commands, %0d checks, %0d errors", n_cmds, checks, errors);
      if (errors == 0 && n_cmds > 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+src
src/mmu_pkg.sv
src/csr_regs.sv
src/stable_timer.sv
src/dmw_translate.sv
src/dtlb_fsm.sv
src/mmu_top.sv
bench/tb_mmu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_mmu_top \
   -o sim_mmu > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_mmu > sim.log 2>&1
grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/csr_regs.sv
`include "mmu_defines.svh"

module csr_regs (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_csr_wen,
   input  logic [`MMU_CSR_BITS-1:0]   i_csr_waddr,
   input  logic [`MMU_GRLEN-1:0]      i_csr_wdata,
   input  logic [`MMU_CSR_BITS-1:0]   i_csr_raddr,
   input  logic [`MMU_GRLEN-1:0]      i_tval,
   input  logic                       i_expire,
   output logic [`MMU_GRLEN-1:0]      o_csr_rdata,
   output mmu_pkg::crmd_t             o_crmd,
   output mmu_pkg::dmw_t              o_dmw0,
   output mmu_pkg::dmw_t              o_dmw1,
   output logic                       o_tcfg_wr,
   output logic                       o_tcfg_en,
   output logic                       o_tcfg_periodic,
   output logic [`TCFG_INIT_BITS-1:0] o_tcfg_init,
   output logic                       o_timer_int
);

   mmu_pkg::csr_word_u    wword;
   mmu_pkg::crmd_t        crmd_q;
   mmu_pkg::crmd_t        crmd_d;
   mmu_pkg::dmw_t         dmw0_q;
   mmu_pkg::dmw_t         dmw1_q;
   mmu_pkg::dmw_t         dmw_d;
   logic [`MMU_GRLEN-1:0] tcfg_q;
   logic [`MMU_GRLEN-1:0] tcfg_src;
   logic                  ti_q;

   // keep only the defined fields of the write word
   always_comb begin
      wword.raw   = i_csr_wdata;
      crmd_d      = '0;
      crmd_d.plv  = wword.crmd.plv;
      crmd_d.ie   = wword.crmd.ie;
      crmd_d.da   = wword.crmd.da;
      crmd_d.pg   = wword.crmd.pg;
      crmd_d.datf = wword.crmd.datf;
      crmd_d.datm = wword.crmd.datm;
      dmw_d       = '0;
      dmw_d.plv0  = wword.dmw.plv0;
      dmw_d.plv3  = wword.dmw.plv3;
      dmw_d.mat   = wword.dmw.mat;
      dmw_d.pseg  = wword.dmw.pseg;
      dmw_d.vseg  = wword.dmw.vseg;
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         crmd_q    <= '0;
         crmd_q.da <= 1'b1;   // come out of reset untranslated
         dmw0_q    <= '0;
         dmw1_q    <= '0;
         tcfg_q    <= '0;
         ti_q      <= 1'b0;
      end else begin
         if (i_csr_wen) begin
            case (i_csr_waddr)
               `CSR_CRMD: crmd_q <= crmd_d;
               `CSR_DMW0: dmw0_q <= dmw_d;
               `CSR_DMW1: dmw1_q <= dmw_d;
               `CSR_TCFG: tcfg_q <= i_csr_wdata;
               default: ;
            endcase
         end
         if (i_expire) begin
            ti_q <= 1'b1;   // expiry beats a same-cycle clear
         end else if (i_csr_wen && (i_csr_waddr == `CSR_TICLR) && i_csr_wdata[0]) begin
            ti_q <= 1'b0;
         end
      end
   end

   // timer sees the new tcfg in the write cycle
   assign o_tcfg_wr       = i_csr_wen && (i_csr_waddr == `CSR_TCFG);
   assign tcfg_src        = o_tcfg_wr ? i_csr_wdata : tcfg_q;
   assign o_tcfg_en       = tcfg_src[`TCFG_EN];
   assign o_tcfg_periodic = tcfg_src[`TCFG_PERIODIC];
   assign o_tcfg_init     = tcfg_src[`MMU_GRLEN-1:`TCFG_INIT_LSB];

   always_comb begin
      o_csr_rdata = '0;
      case (i_csr_raddr)
         `CSR_CRMD:  o_csr_rdata = crmd_q;
         `CSR_ESTAT: o_csr_rdata[`ESTAT_TI] = ti_q;
         `CSR_TCFG:  o_csr_rdata = tcfg_q;
         `CSR_TVAL:  o_csr_rdata = i_tval;
         `CSR_DMW0:  o_csr_rdata = dmw0_q;
         `CSR_DMW1:  o_csr_rdata = dmw1_q;
         default:    o_csr_rdata = '0;   // ticlr reads zero too
      endcase
   end

   assign o_crmd      = crmd_q;
   assign o_dmw0      = dmw0_q;
   assign o_dmw1      = dmw1_q;
   assign o_timer_int = ti_q & crmd_q.ie;

endmodule

//--- src/dmw_translate.sv
`include "mmu_defines.svh"

module dmw_translate (
   input  logic [`MMU_GRLEN-1:0]    i_vaddr,
   input  mmu_pkg::crmd_t           i_crmd,
   input  mmu_pkg::dmw_t            i_dmw0,
   input  mmu_pkg::dmw_t            i_dmw1,
   output logic [`MMU_PABITS-1:0]   o_paddr,
   output logic                     o_hit,
   output logic                     o_uncache,
   output logic [`MMU_EXC_BITS-1:0] o_exccode
);

   // plv 1 and 2 never match a window
   function automatic logic win_match(input mmu_pkg::dmw_t win,
                                      input logic [1:0]    plv,
                                      input logic [2:0]    vseg);
      logic plv_ok;
      plv_ok = ((plv == 2'd0) && win.plv0) || ((plv == 2'd3) && win.plv3);
      return plv_ok && (win.vseg == vseg);
   endfunction

   logic [2:0]    vseg;
   logic          hit0;
   logic          hit1;
   mmu_pkg::dmw_t sel;

   assign vseg = i_vaddr[`MMU_GRLEN-1 -: 3];
   assign hit0 = win_match(i_dmw0, i_crmd.plv, vseg);
   assign hit1 = win_match(i_dmw1, i_crmd.plv, vseg);
   assign sel  = hit0 ? i_dmw0 : i_dmw1;   // dmw0 has priority

   always_comb begin
      if (i_crmd.da) begin
         o_paddr   = i_vaddr[`MMU_PABITS-1:0];
         o_hit     = 1'b1;
         o_uncache = (i_crmd.datm == 2'd0);
         o_exccode = '0;
      end else if (hit0 || hit1) begin
         o_paddr   = {sel.pseg, i_vaddr[`MMU_GRLEN-4:0]};
         o_hit     = 1'b1;
         o_uncache = (sel.mat == 2'd0);
         o_exccode = '0;
      end else begin
         // no page table here, so a miss is a refill
         o_paddr   = '0;
         o_hit     = 1'b0;
         o_uncache = 1'b0;
         o_exccode = `EXC_TLBR;
      end
   end

endmodule

//--- src/dtlb_fsm.sv
`include "mmu_defines.svh"

module dtlb_fsm (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_req,
   input  logic                     i_cache_recv,
   input  logic [`MMU_PABITS-1:0]   i_paddr,
   input  logic                     i_hit,
   input  logic                     i_uncache,
   input  logic [`MMU_EXC_BITS-1:0] i_exccode,
   output logic                     o_finish,
   output logic [`MMU_PABITS-1:0]   o_paddr,
   output logic                     o_hit,
   output logic                     o_uncache,
   output logic [`MMU_EXC_BITS-1:0] o_exccode
);

   typedef enum logic {
      IDLE,
      DONE
   } state_t;

   state_t                   state_q;
   logic                     accept;
   logic [`MMU_PABITS-1:0]   paddr_q;
   logic                     hit_q;
   logic                     uncache_q;
   logic [`MMU_EXC_BITS-1:0] exccode_q;

   assign accept = (state_q == IDLE) && i_req;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE: if (i_req) state_q <= DONE;
            DONE: if (i_cache_recv) state_q <= IDLE;   // wait for the cache to take it
            default: state_q <= IDLE;
         endcase
      end
   end

   // result frozen from acceptance until recv
   always_ff @(posedge i_clk) begin
      if (accept) begin
         paddr_q   <= i_paddr;
         hit_q     <= i_hit;
         uncache_q <= i_uncache;
         exccode_q <= i_exccode;
      end
   end

   assign o_finish  = (state_q == DONE);
   assign o_paddr   = paddr_q;
   assign o_hit     = hit_q;
   assign o_uncache = uncache_q;
   assign o_exccode = exccode_q;

endmodule

//--- src/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

`define MMU_GRLEN      32
`define MMU_PABITS     32
`define MMU_CSR_BITS   14
`define MMU_EXC_BITS   6

// csr addresses
`define CSR_CRMD       14'h000
`define CSR_ESTAT      14'h005
`define CSR_TCFG       14'h041
`define CSR_TVAL       14'h042
`define CSR_TICLR      14'h044
`define CSR_DMW0       14'h180
`define CSR_DMW1       14'h181

// tcfg layout
`define TCFG_EN        0
`define TCFG_PERIODIC  1
`define TCFG_INIT_LSB  2
`define TCFG_INIT_BITS (`MMU_GRLEN - `TCFG_INIT_LSB)

`define ESTAT_TI       11

// tlb refill
`define EXC_TLBR       6'h3f

`endif

//--- src/mmu_pkg.sv
`include "mmu_defines.svh"

package mmu_pkg;

   // current mode register
   typedef struct packed {
      logic [22:0] rsvd;
      logic [1:0]  datm;   // data access type in da mode
      logic [1:0]  datf;   // fetch access type in da mode
      logic        pg;
      logic        da;
      logic        ie;
      logic [1:0]  plv;
   } crmd_t;

   // direct map window
   typedef struct packed {
      logic [2:0]  vseg;
      logic        rsvd_28;
      logic [2:0]  pseg;
      logic [18:0] rsvd_24_6;
      logic [1:0]  mat;    // 0 is strongly ordered uncached
      logic        plv3;
      logic [1:0]  rsvd_2_1;
      logic        plv0;
   } dmw_t;

   // one write word seen as either register layout
   typedef union packed {
      logic [`MMU_GRLEN-1:0] raw;
      crmd_t                 crmd;
      dmw_t                  dmw;
   } csr_word_u;

endpackage

//--- src/mmu_top.sv
`include "mmu_defines.svh"

module mmu_top (
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_csr_wen,
   input  logic [`MMU_CSR_BITS-1:0] i_csr_waddr,
   input  logic [`MMU_GRLEN-1:0]    i_csr_wdata,
   input  logic [`MMU_CSR_BITS-1:0] i_csr_raddr,
   output logic [`MMU_GRLEN-1:0]    o_csr_rdata,
   input  logic                     i_data_tlb_req,
   input  logic                     i_data_tlb_wr,      // no effect without page permissions
   input  logic [`MMU_GRLEN-1:0]    i_data_tlb_vaddr,
   input  logic                     i_dtlb_cache_recv,
   output logic                     o_dtlb_finish,
   output logic                     o_dtlb_hit,
   output logic [`MMU_PABITS-1:0]   o_dtlb_paddr,
   output logic                     o_dtlb_uncache,
   output logic [`MMU_EXC_BITS-1:0] o_dtlb_exccode,
   output logic                     o_timer_int
);

   mmu_pkg::crmd_t             crmd;
   mmu_pkg::dmw_t              dmw0;
   mmu_pkg::dmw_t              dmw1;
   logic                       tcfg_wr;
   logic                       tcfg_en;
   logic                       tcfg_periodic;
   logic [`TCFG_INIT_BITS-1:0] tcfg_init;
   logic [`MMU_GRLEN-1:0]      tval;
   logic                       expire;
   logic [`MMU_PABITS-1:0]     xlat_paddr;
   logic                       xlat_hit;
   logic                       xlat_uncache;
   logic [`MMU_EXC_BITS-1:0]   xlat_exccode;

   csr_regs u_csr_regs (
      .i_clk           (i_clk        ),
      .i_rst_n         (i_rst_n      ),
      .i_csr_wen       (i_csr_wen    ),
      .i_csr_waddr     (i_csr_waddr  ),
      .i_csr_wdata     (i_csr_wdata  ),
      .i_csr_raddr     (i_csr_raddr  ),
      .i_tval          (tval         ),
      .i_expire        (expire       ),
      .o_csr_rdata     (o_csr_rdata  ),
      .o_crmd          (crmd         ),
      .o_dmw0          (dmw0         ),
      .o_dmw1          (dmw1         ),
      .o_tcfg_wr       (tcfg_wr      ),
      .o_tcfg_en       (tcfg_en      ),
      .o_tcfg_periodic (tcfg_periodic),
      .o_tcfg_init     (tcfg_init    ),
      .o_timer_int     (o_timer_int  )
   );

   stable_timer u_stable_timer (
      .i_clk      (i_clk        ),
      .i_rst_n    (i_rst_n      ),
      .i_load     (tcfg_wr      ),
      .i_en       (tcfg_en      ),
      .i_periodic (tcfg_periodic),
      .i_init     (tcfg_init    ),
      .o_tval     (tval         ),
      .o_expire   (expire       )
   );

   dmw_translate u_dmw_translate (
      .i_vaddr   (i_data_tlb_vaddr),
      .i_crmd    (crmd            ),
      .i_dmw0    (dmw0            ),
      .i_dmw1    (dmw1            ),
      .o_paddr   (xlat_paddr      ),
      .o_hit     (xlat_hit        ),
      .o_uncache (xlat_uncache    ),
      .o_exccode (xlat_exccode    )
   );

   dtlb_fsm u_dtlb_fsm (
      .i_clk        (i_clk            ),
      .i_rst_n      (i_rst_n          ),
      .i_req        (i_data_tlb_req   ),
      .i_cache_recv (i_dtlb_cache_recv),
      .i_paddr      (xlat_paddr       ),
      .i_hit        (xlat_hit         ),
      .i_uncache    (xlat_uncache     ),
      .i_exccode    (xlat_exccode     ),
      .o_finish     (o_dtlb_finish    ),
      .o_paddr      (o_dtlb_paddr     ),
      .o_hit        (o_dtlb_hit       ),
      .o_uncache    (o_dtlb_uncache   ),
      .o_exccode    (o_dtlb_exccode   )
   );

endmodule

//--- src/stable_timer.sv
`include "mmu_defines.svh"

module stable_timer (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   input  logic                       i_load,
   input  logic                       i_en,
   input  logic                       i_periodic,
   input  logic [`TCFG_INIT_BITS-1:0] i_init,
   output logic [`MMU_GRLEN-1:0]      o_tval,
   output logic                       o_expire
);

   logic [`MMU_GRLEN-1:0] tval_q;
   logic [`MMU_GRLEN-1:0] reload;
   logic                  run_q;

   assign reload = {i_init, {`TCFG_INIT_LSB{1'b0}}};   // initval << 2

   // one cycle at zero while running
   assign o_expire = run_q && (tval_q == '0);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         tval_q <= '0;
         run_q  <= 1'b0;
      end else if (i_load) begin
         tval_q <= reload;
         run_q  <= i_en;
      end else if (o_expire) begin
         if (i_periodic) begin
            tval_q <= reload;
         end else begin
            run_q <= 1'b0;   // one-shot parks at zero
         end
      end else if (run_q) begin
         tval_q <= tval_q - 1'b1;
      end
   end

   assign o_tval = tval_q;

endmodule
